//--- axi_pkg.sv
package axi_pkg;

    // Read channel field types
    typedef logic [1:0] resp_t;
    typedef logic [7:0] len_t;
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;

    // Single word transfers only
    localparam size_t  SIZE_WORD  = 3'b010;
    localparam burst_t BURST_INCR = 2'b01;

endpackage

//--- fetch_pkg.sv
package fetch_pkg;

    // Byte address, instruction word and exception cause
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [31:0] cause_t;

    // Fetch exception causes
    localparam cause_t CAUSE_MISALIGNED   = 32'd0;
    localparam cause_t CAUSE_ACCESS_FAULT = 32'd1;

    // First fetch address after reset
    localparam addr_t RESET_VECTOR = 32'h0000_2000;

    // Instruction memory window
    localparam addr_t ROM_BASE  = 32'h0000_2000;
    localparam int    ROM_WORDS = 64;

    // Command from execute, applies to the item being transferred
    typedef enum logic [0:0] {
        CMD_NONE = 1'b0,
        CMD_JUMP = 1'b1
    } e2f_cmd_t;

    // Kill means a cancelled read still owes its response
    typedef enum logic [0:0] {
        ST_ACTIVE = 1'b0,
        ST_KILL   = 1'b1
    } fetch_state_t;

endpackage

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,

    // AR channel
    output logic                    arvalid,
    input  logic                    arready,
    output fetch_pkg::addr_t        araddr,
    output axi_pkg::len_t           arlen,
    output axi_pkg::size_t          arsize,
    output axi_pkg::burst_t         arburst,

    // R channel
    input  logic                    rvalid,
    output logic                    rready,
    input  fetch_pkg::instr_t       rdata,
    input  axi_pkg::resp_t          rresp,

    // Towards decode
    output logic                    f2d_valid,
    output fetch_pkg::instr_t       f2d_instr,
    output fetch_pkg::addr_t        f2d_pc,
    output logic                    f2d_exception,
    output fetch_pkg::cause_t       f2d_cause,

    // From decode and execute
    input  logic                    d2f_ready,
    input  fetch_pkg::e2f_cmd_t     d2f_cmd,
    input  fetch_pkg::addr_t        e2f_jump_target
);

    fetch_pkg::addr_t           pc;
    fetch_pkg::addr_t           pc_next;
    fetch_pkg::fetch_state_t    state;
    fetch_pkg::fetch_state_t    state_next;

    // AR request raised, waiting for arready
    logic                       ar_pending;
    // AR accepted, R response still owed
    logic                       req_pending;
    fetch_pkg::addr_t           req_pc;

    // Output register towards decode
    logic                       out_valid;
    fetch_pkg::instr_t          out_instr;
    fetch_pkg::addr_t           out_pc;
    logic                       out_exception;
    fetch_pkg::cause_t          out_cause;

    logic                       f2d_fire;
    logic                       jump;
    logic                       ar_fire;
    logic                       r_fire;
    logic                       out_free;
    logic                       pc_misaligned;
    logic                       read_left;
    logic                       issue;
    logic                       misaligned_item;
    logic                       take_resp;
    logic                       resp_ok;

    // Handshakes
    assign f2d_fire = out_valid && d2f_ready;
    assign jump     = f2d_fire && (d2f_cmd == fetch_pkg::CMD_JUMP);
    assign ar_fire  = ar_pending && arready;
    assign r_fire   = rvalid && rready;

    // Output register empties this cycle or already is
    assign out_free      = !out_valid || d2f_ready;
    assign pc_misaligned = |pc[1:0];
    assign resp_ok       = (rresp == axi_pkg::RESP_OKAY);

    // A read that still produces a response after this cycle
    assign read_left = ar_pending || (req_pending && !r_fire);

    // Killed responses are always accepted
    assign rready = req_pending && ((state == fetch_pkg::ST_KILL) || out_free);

    // New read once the previous response is in, may overlap the R transfer
    assign issue = (state == fetch_pkg::ST_ACTIVE) && !jump && !ar_pending &&
                   (!req_pending || r_fire) && !pc_misaligned;

    // Misaligned pc turns into an item without any bus traffic
    assign misaligned_item = (state == fetch_pkg::ST_ACTIVE) && !jump && !ar_pending &&
                             !req_pending && pc_misaligned && out_free;

    // Response goes to the output unless a jump discards it
    assign take_resp = r_fire && (state == fetch_pkg::ST_ACTIVE) && !jump;

    // Next pc
    always_comb begin
        pc_next = pc;
        if (jump) begin
            pc_next = e2f_jump_target;
        end else if ((ar_fire && (state == fetch_pkg::ST_ACTIVE)) || misaligned_item) begin
            pc_next = pc + 32'd4;
        end
    end

    // Kill until the cancelled response has been taken
    always_comb begin
        state_next = state;
        if (jump && read_left) begin
            state_next = fetch_pkg::ST_KILL;
        end else if ((state == fetch_pkg::ST_KILL) && r_fire) begin
            state_next = fetch_pkg::ST_ACTIVE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= fetch_pkg::RESET_VECTOR;
            state       <= fetch_pkg::ST_ACTIVE;
            ar_pending  <= 1'b0;
            req_pending <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            pc    <= pc_next;
            state <= state_next;

            if (ar_fire) begin
                ar_pending <= 1'b0;
            end else if (issue) begin
                ar_pending <= 1'b1;
            end

            if (ar_fire) begin
                req_pending <= 1'b1;
            end else if (r_fire) begin
                req_pending <= 1'b0;
            end

            if (take_resp || misaligned_item) begin
                out_valid <= 1'b1;
            end else if (f2d_fire) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Request address and output payload
    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc;
        end

        if (take_resp) begin
            out_pc        <= req_pc;
            out_instr     <= resp_ok ? rdata : '0;
            out_exception <= !resp_ok;
            out_cause     <= resp_ok ? '0 : fetch_pkg::CAUSE_ACCESS_FAULT;
        end else if (misaligned_item) begin
            out_pc        <= pc;
            out_instr     <= '0;
            out_exception <= 1'b1;
            out_cause     <= fetch_pkg::CAUSE_MISALIGNED;
        end
    end

    // AR channel, single word reads only
    assign arvalid = ar_pending;
    assign araddr  = req_pc;
    assign arlen   = '0;
    assign arsize  = axi_pkg::SIZE_WORD;
    assign arburst = axi_pkg::BURST_INCR;

    assign f2d_valid     = out_valid;
    assign f2d_instr     = out_instr;
    assign f2d_pc        = out_pc;
    assign f2d_exception = out_exception;
    assign f2d_cause     = out_cause;

endmodule

//--- instr_rom_axi.sv
`timescale 1ns/1ps

module instr_rom_axi #(
    parameter int LATENCY = 2
) (
    input  logic                clk,
    input  logic                rst,

    // AR channel
    input  logic                arvalid,
    output logic                arready,
    input  fetch_pkg::addr_t    araddr,
    input  axi_pkg::len_t       arlen,
    input  axi_pkg::size_t      arsize,
    input  axi_pkg::burst_t     arburst,

    // R channel
    output logic                rvalid,
    input  logic                rready,
    output fetch_pkg::instr_t   rdata,
    output axi_pkg::resp_t      rresp
);

    typedef logic [$clog2(LATENCY + 1)-1:0] cnt_t;

    fetch_pkg::instr_t  rom [fetch_pkg::ROM_WORDS];

    logic               busy;
    cnt_t               wait_cnt;
    logic               ar_fire;
    logic               r_fire;
    fetch_pkg::addr_t   offset;
    logic               in_range;
    logic               single_word;
    logic               req_ok;

    initial begin
        $readmemh("rom_image.hex", rom);
    end

    // One read served at a time
    assign arready = !busy;
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // Offset wraps to a large value below the base
    assign offset   = araddr - fetch_pkg::ROM_BASE;
    assign in_range = offset < fetch_pkg::addr_t'(4 * fetch_pkg::ROM_WORDS);

    assign single_word = (arlen == '0) && (arsize == axi_pkg::SIZE_WORD) &&
                         (arburst == axi_pkg::BURST_INCR);
    assign req_ok      = in_range && single_word;

    // Latency countdown, rvalid held until rready
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            rvalid   <= 1'b0;
            wait_cnt <= '0;
        end else if (ar_fire) begin
            busy     <= 1'b1;
            wait_cnt <= cnt_t'(LATENCY - 1);
            rvalid   <= (LATENCY == 1);
        end else if (r_fire) begin
            busy   <= 1'b0;
            rvalid <= 1'b0;
        end else if (busy && !rvalid) begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == cnt_t'(1)) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Result captured with the request and held through the wait
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= req_ok ? rom[offset[$clog2(fetch_pkg::ROM_WORDS) + 1:2]] : '0;
            rresp <= req_ok ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
        end
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    d2f_ready,
    input  fetch_pkg::e2f_cmd_t     d2f_cmd,
    input  fetch_pkg::addr_t        e2f_jump_target,

    output logic                    f2d_valid,
    output fetch_pkg::instr_t       f2d_instr,
    output fetch_pkg::addr_t        f2d_pc,
    output logic                    f2d_exception,
    output fetch_pkg::cause_t       f2d_cause
);

    // AR channel
    logic               arvalid;
    logic               arready;
    fetch_pkg::addr_t   araddr;
    axi_pkg::len_t      arlen;
    axi_pkg::size_t     arsize;
    axi_pkg::burst_t    arburst;

    // R channel
    logic               rvalid;
    logic               rready;
    fetch_pkg::instr_t  rdata;
    axi_pkg::resp_t     rresp;

    fetch_unit u_fetch (
        .clk             (clk),
        .rst             (rst),
        .arvalid         (arvalid),
        .arready         (arready),
        .araddr          (araddr),
        .arlen           (arlen),
        .arsize          (arsize),
        .arburst         (arburst),
        .rvalid          (rvalid),
        .rready          (rready),
        .rdata           (rdata),
        .rresp           (rresp),
        .f2d_valid       (f2d_valid),
        .f2d_instr       (f2d_instr),
        .f2d_pc          (f2d_pc),
        .f2d_exception   (f2d_exception),
        .f2d_cause       (f2d_cause),
        .d2f_ready       (d2f_ready),
        .d2f_cmd         (d2f_cmd),
        .e2f_jump_target (e2f_jump_target)
    );

    instr_rom_axi #(
        .LATENCY (2)
    ) u_rom (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

//--- fetch_properties.sv
`timescale 1ns/1ps

module fetch_properties (
    input  logic                clk,
    input  logic                rst,
    input  logic                arvalid,
    input  logic                arready,
    input  fetch_pkg::addr_t    araddr,
    input  logic                rvalid,
    input  logic                rready,
    input  fetch_pkg::instr_t   rdata,
    input  logic                f2d_valid,
    input  fetch_pkg::instr_t   f2d_instr,
    input  fetch_pkg::addr_t    f2d_pc,
    input  logic                f2d_exception,
    input  fetch_pkg::cause_t   f2d_cause,
    input  logic                d2f_ready
);

    // AR request holds until the slave accepts it
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR request changed before arready");

    // Decode side item held under back-pressure
    f2d_hold: assert property (@(posedge clk) disable iff (rst)
        f2d_valid && !d2f_ready |=> f2d_valid && $stable(f2d_instr) && $stable(f2d_pc) &&
        $stable(f2d_exception) && $stable(f2d_cause))
        else $error("Decode side item changed while stalled");

    // Read data holds until rready
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("R response changed before rready");

endmodule

bind fetch_top fetch_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .arvalid       (arvalid),
    .arready       (arready),
    .araddr        (araddr),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .f2d_valid     (f2d_valid),
    .f2d_instr     (f2d_instr),
    .f2d_pc        (f2d_pc),
    .f2d_exception (f2d_exception),
    .f2d_cause     (f2d_cause),
    .d2f_ready     (d2f_ready)
);

//--- fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int NUM_ROWS      = 8;
    localparam int ROW_CYCLES    = 200;
    localparam int RESET_CYCLES  = 10;

    typedef enum logic [1:0] {
        STALL_NONE,
        STALL_FIXED,
        STALL_RANDOM
    } stall_t;

    // Items to accept, stall mode, command and target on the last item
    typedef struct packed {
        logic [7:0]             count;
        stall_t                 stall;
        fetch_pkg::e2f_cmd_t    cmd;
        fetch_pkg::addr_t       target;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   d2f_ready;
    fetch_pkg::e2f_cmd_t    d2f_cmd;
    fetch_pkg::addr_t       e2f_jump_target;
    logic                   f2d_valid;
    fetch_pkg::instr_t      f2d_instr;
    fetch_pkg::addr_t       f2d_pc;
    logic                   f2d_exception;
    fetch_pkg::cause_t      f2d_cause;

    row_t                   rows [NUM_ROWS];
    fetch_pkg::instr_t      rom_copy [fetch_pkg::ROM_WORDS];
    fetch_pkg::addr_t       exp_pc;

    fetch_top UUT (
        .clk             (clk),
        .rst             (rst),
        .d2f_ready       (d2f_ready),
        .d2f_cmd         (d2f_cmd),
        .e2f_jump_target (e2f_jump_target),
        .f2d_valid       (f2d_valid),
        .f2d_instr       (f2d_instr),
        .f2d_pc          (f2d_pc),
        .f2d_exception   (f2d_exception),
        .f2d_cause       (f2d_cause)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Ready pattern for one decode cycle
    function automatic logic ready_for(stall_t mode, int cycle);
        case (mode)
            STALL_FIXED:  return (cycle % 3) == 2;
            STALL_RANDOM: return ($urandom() % 2) == 0;
            default:      return 1'b1;
        endcase
    endfunction

    // Compare the item on the decode side with the reference model
    task automatic check_item;
        logic               exp_exc;
        fetch_pkg::cause_t  exp_cause;
        fetch_pkg::instr_t  exp_instr;
        logic               in_rom;
        in_rom = (exp_pc >= fetch_pkg::ROM_BASE) &&
                 (exp_pc < fetch_pkg::ROM_BASE + 4 * fetch_pkg::ROM_WORDS);
        if (exp_pc[1:0] != 2'b00) begin
            exp_exc   = 1'b1;
            exp_cause = fetch_pkg::CAUSE_MISALIGNED;
            exp_instr = '0;
        end else if (!in_rom) begin
            exp_exc   = 1'b1;
            exp_cause = fetch_pkg::CAUSE_ACCESS_FAULT;
            exp_instr = '0;
        end else begin
            exp_exc   = 1'b0;
            exp_cause = '0;
            exp_instr = rom_copy[int'((exp_pc - fetch_pkg::ROM_BASE) >> 2)];
        end
        assert (f2d_pc == exp_pc && f2d_exception == exp_exc && f2d_instr == exp_instr &&
                (!exp_exc || f2d_cause == exp_cause)) else begin
            $write("[FAIL] %0t pc %h exc %b cause %0d instr %h",
                   $time, exp_pc, exp_exc, exp_cause, exp_instr);
            $display(", got pc %h exc %b cause %0d instr %h",
                     f2d_pc, f2d_exception, f2d_cause, f2d_instr);
            $display("Testbench failed");
            $fatal(1, "Decode side item mismatch");
        end
    endtask

    // Hang guard sized from the table length
    initial begin
        repeat (RESET_CYCLES + NUM_ROWS * ROW_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_ROWS * ROW_CYCLES);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int     accepted;
        int     cycle;
        logic   last;
        void'($urandom(9594));
        rst             = 1'b1;
        d2f_ready       = 1'b0;
        d2f_cmd         = fetch_pkg::CMD_NONE;
        e2f_jump_target = '0;
        $readmemh("rom_image.hex", rom_copy);

        // Sequential start, stalls, jump with a read in flight, misaligned,
        // out of range on both sides, back into the ROM and off its end
        rows = '{
            '{8'd6, STALL_NONE,   fetch_pkg::CMD_NONE, 32'h0000_0000},
            '{8'd5, STALL_FIXED,  fetch_pkg::CMD_NONE, 32'h0000_0000},
            '{8'd6, STALL_RANDOM, fetch_pkg::CMD_JUMP, 32'h0000_2080},
            '{8'd4, STALL_NONE,   fetch_pkg::CMD_JUMP, 32'h0000_2022},
            '{8'd3, STALL_RANDOM, fetch_pkg::CMD_JUMP, 32'h0000_2100},
            '{8'd3, STALL_FIXED,  fetch_pkg::CMD_JUMP, 32'h0000_1ffc},
            '{8'd2, STALL_NONE,   fetch_pkg::CMD_JUMP, 32'h0000_20f8},
            '{8'd8, STALL_RANDOM, fetch_pkg::CMD_NONE, 32'h0000_0000}
        };
        exp_pc = fetch_pkg::RESET_VECTOR;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            accepted = 0;
            cycle    = 0;
            while (accepted < int'(rows[r].count)) begin
                @(negedge clk);
                last      = (accepted == int'(rows[r].count) - 1);
                d2f_ready = ready_for(rows[r].stall, cycle);
                cycle++;
                d2f_cmd         = last ? rows[r].cmd : fetch_pkg::CMD_NONE;
                e2f_jump_target = last ? rows[r].target : '0;
                // Transfer happens on the coming rising edge
                if (d2f_ready && f2d_valid) begin
                    check_item();
                    if (last && rows[r].cmd == fetch_pkg::CMD_JUMP) begin
                        exp_pc = rows[r].target;
                    end else begin
                        exp_pc = exp_pc + 32'd4;
                    end
                    accepted++;
                end
            end
        end

        @(negedge clk);
        d2f_ready = 1'b0;
        d2f_cmd   = fetch_pkg::CMD_NONE;
        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- rom_image.hex
// One 32-bit instruction word per line, the first line at ROM_BASE
// Each word carries its own byte address in the low 24 bits
13002000
13002004
13002008
1300200c
13002010
13002014
13002018
1300201c
13002020
13002024
13002028
1300202c
13002030
13002034
13002038
1300203c
13002040
13002044
13002048
1300204c
13002050
13002054
13002058
1300205c
13002060
13002064
13002068
1300206c
13002070
13002074
13002078
1300207c
13002080
13002084
13002088
1300208c
13002090
13002094
13002098
1300209c
130020a0
130020a4
130020a8
130020ac
130020b0
130020b4
130020b8
130020bc
130020c0
130020c4
130020c8
130020cc
130020d0
130020d4
130020d8
130020dc
130020e0
130020e4
130020e8
130020ec
130020f0
130020f4
130020f8
130020fc

//--- flist.f
axi_pkg.sv
fetch_pkg.sv
fetch_unit.sv
instr_rom_axi.sv
fetch_top.sv
fetch_properties.sv
fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch testbench with Verilator and run it from the project root

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f flist.f --top-module fetch_tb -o fetch_sim \
    > build.log 2>&1 || { cat build.log; echo "FAILED: build error"; exit 1; }

./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "FAILED: run ended early"; exit 1; }
echo "PASSED"
exit 0
